/* run_sim.sh */
#!/bin/sh
# Build and run the memory stage testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mem_stage_tb -Mdir obj_dir -f src.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vmem_stage_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

/* src.f */
verilog/mem_stage_pkg.sv
verilog/mem_stage_ifs.sv
verilog/apb_cmd_port.sv
verilog/access_decode.sv
verilog/data_mem.sv
verilog/load_result.sv
verilog/mem_stage_top.sv
testbench/mem_stage_props.sv
testbench/mem_stage_tb.sv

/* testbench/mem_stage_props.sv */
`timescale 1ns/1ns

module mem_stage_props (
    input logic clk,
    input logic rst_n,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic fault,
    input logic req_valid,
    input logic result_valid
);

    // failed assertions so far.
    int fail_count = 0;

    // no wait states.
    a_pready_high: assert property (@(posedge clk) pready)
        else
        begin
            fail_count++;
            $error("pready went low");
        end

    a_pslverr_access: assert property (@(posedge clk) pslverr |-> (psel && penable))
        else
        begin
            fail_count++;
            $error("pslverr outside an access phase");
        end

    // a faulting access is dropped.
    a_fault_or_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !(fault && req_valid))
        else
        begin
            fail_count++;
            $error("fault and req valid in the same cycle");
        end

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (!req_valid && !fault && !result_valid))
        else
        begin
            fail_count++;
            $error("valid bit set during reset");
        end

endmodule

bind mem_stage_top mem_stage_props i_mem_stage_props (
    .clk          (clk),
    .rst_n        (rst_n),
    .psel         (psel),
    .penable      (penable),
    .pready       (pready),
    .pslverr      (pslverr),
    .fault        (fault),
    .req_valid    (req.valid),
    .result_valid (result_valid)
);

/* testbench/mem_stage_tb.sv */
`timescale 1ns/1ns

module mem_stage_tb;

    typedef struct packed {
        mem_stage_pkg::word_t          addr;
        mem_stage_pkg::word_t          wdata;
        mem_stage_pkg::funct3_t        funct3;
        logic                          store;
        mem_stage_pkg::result_src_t    result_src;
        mem_stage_pkg::word_t          exp_result;
        logic                          exp_fault;
    } op_t;

    localparam int MAX_ROWS   = 32;
    localparam int INIT_WORDS = 16;
    localparam int NUM_RANDOM = 200;

    logic                     clk;
    logic                     rst_n;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    mem_stage_pkg::paddr_t    paddr;
    mem_stage_pkg::word_t     pwdata;
    mem_stage_pkg::word_t     prdata;
    logic                     pready;
    logic                     pslverr;

    op_t                      ops [MAX_ROWS];
    int                       n_rows;
    int                       seed;
    // byte-wide model of the data memory, indexed by the wrapped address.
    logic [7:0]               ref_mem [1024];

    mem_stage_top i_mem_stage_top (
        .clk     (clk),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #10 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input mem_stage_pkg::word_t got,
                              input mem_stage_pkg::word_t exp);
        if (got !== exp)
        begin
            fail_run($sformatf("Error: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_status(input mem_stage_pkg::word_t got,
                                input mem_stage_pkg::word_t exp);
        if (got !== exp)
        begin
            fail_run($sformatf("Error: STATUS got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp,
                              input mem_stage_pkg::paddr_t addr);
        if (got !== exp)
        begin
            fail_run($sformatf("Error: %s got 0x%h expected 0x%h at paddr 0x%h",
                               name, got, exp, addr));
        end
    endtask

    // setup phase, access phase, then back to idle.
    task automatic apb_write(input mem_stage_pkg::paddr_t addr, input mem_stage_pkg::word_t data,
                             input logic exp_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        check_flag("pready", pready, 1'b1, addr);
        check_flag("pslverr", pslverr, exp_err, addr);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input mem_stage_pkg::paddr_t addr, output mem_stage_pkg::word_t data,
                            input logic exp_err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        pwdata  = '0;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        check_flag("pready", pready, 1'b1, addr);
        check_flag("pslverr", pslverr, exp_err, addr);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_idle(output mem_stage_pkg::word_t status, output int polls);
        polls  = 0;
        status = 32'h1;
        while (status[0])
        begin
            if (polls == 10)
            begin
                fail_run("STATUS busy did not clear after a command");
            end
            apb_read(mem_stage_pkg::REG_STATUS, status, 1'b0);
            polls++;
        end
    endtask

    task automatic run_op(input op_t op);
        mem_stage_pkg::word_t data;
        int                   polls;
        apb_write(mem_stage_pkg::REG_ADDR, op.addr, 1'b0);
        apb_write(mem_stage_pkg::REG_WDATA, op.wdata, 1'b0);
        apb_write(mem_stage_pkg::REG_CMD, {26'b0, op.result_src, op.store, op.funct3}, 1'b0);
        wait_idle(data, polls);
        // an access in flight keeps busy set past the first poll.
        if (!op.exp_fault && polls < 2)
        begin
            fail_run("STATUS busy was not set while an access was in flight");
        end
        check_status(data, {30'b0, op.exp_fault, 1'b0});
        apb_read(mem_stage_pkg::REG_RESULT, data, 1'b0);
        check_word("RESULT", data, op.exp_result);
        if (op.exp_fault)
        begin
            apb_write(mem_stage_pkg::REG_STATUS, 32'h2, 1'b0);
            apb_read(mem_stage_pkg::REG_STATUS, data, 1'b0);
            check_status(data, 32'h0);
        end
    endtask

    // extension and select as the rv32 rules define them.
    function automatic mem_stage_pkg::word_t expect_result(input mem_stage_pkg::word_t addr,
            input mem_stage_pkg::funct3_t funct3, input mem_stage_pkg::result_src_t src,
            input mem_stage_pkg::word_t old_word);
        logic [7:0]              b;
        logic [15:0]             h;
        mem_stage_pkg::word_t    loaded;
        mem_stage_pkg::word_t    wrapped;
        case (addr[1:0])
            2'd0:    b = old_word[7:0];
            2'd1:    b = old_word[15:8];
            2'd2:    b = old_word[23:16];
            default: b = old_word[31:24];
        endcase
        h = addr[1] ? old_word[31:16] : old_word[15:0];
        case (funct3)
            mem_stage_pkg::F3_B:  loaded = {{24{b[7]}}, b};
            mem_stage_pkg::F3_BU: loaded = {24'b0, b};
            mem_stage_pkg::F3_H:  loaded = {{16{h[15]}}, h};
            mem_stage_pkg::F3_HU: loaded = {16'b0, h};
            default:              loaded = old_word;
        endcase
        // the execute stage reports the address wrapped to the memory size.
        wrapped = {22'b0, addr[9:0]};
        case (src)
            mem_stage_pkg::RES_MEM:  return loaded;
            mem_stage_pkg::RES_ADDR: return wrapped;
            mem_stage_pkg::RES_LINK: return wrapped + 32'd4;
            default:                 return 32'h0;
        endcase
    endfunction

    task automatic run_random(input int count, input logic init);
        op_t                     op;
        int                      r;
        int                      r2;
        int                      nbytes;
        logic [1:0]              off;
        logic [3:0]              idx;
        logic [9:0]              base;
        mem_stage_pkg::word_t    old_word;
        for (int i = 0; i < count; i++)
        begin
            r             = $random(seed);
            r2            = $random(seed);
            op.wdata      = $random(seed);
            op.store      = r[0];
            op.funct3     = r[3:1];
            op.result_src = r[7:6];
            if (op.store && op.funct3 > mem_stage_pkg::F3_W)
                op.funct3 = mem_stage_pkg::F3_W;
            if (!op.store && (op.funct3 == 3'd3 || op.funct3 > mem_stage_pkg::F3_HU))
                op.funct3 = mem_stage_pkg::F3_W;
            off = r[5:4];
            idx = r2[5:2];
            // fill pass, one word store per entry.
            if (init)
            begin
                op.store      = 1'b1;
                op.funct3     = mem_stage_pkg::F3_W;
                op.result_src = mem_stage_pkg::RES_ADDR;
                idx           = i[3:0];
            end
            nbytes = 1 << op.funct3[1:0];
            if (nbytes == 2)
                off[0] = 1'b0;
            else if (nbytes == 4)
                off = 2'b00;
            // random upper bits alias onto the same entries.
            op.addr = {r2[31:10], 4'b0000, idx, off};
            base = {op.addr[9:2], 2'b00};
            old_word = {ref_mem[base + 10'd3], ref_mem[base + 10'd2],
                        ref_mem[base + 10'd1], ref_mem[base]};
            op.exp_result = expect_result(op.addr, op.funct3, op.result_src, old_word);
            op.exp_fault  = 1'b0;
            if (op.store)
            begin
                for (int k = 0; k < nbytes; k++)
                    ref_mem[op.addr[9:0] + 10'(k)] = op.wdata[8*k +: 8];
            end
            run_op(op);
        end
    endtask

    task automatic add_row(input mem_stage_pkg::word_t addr, input mem_stage_pkg::word_t wdata,
                           input mem_stage_pkg::funct3_t funct3, input logic store,
                           input mem_stage_pkg::result_src_t src,
                           input mem_stage_pkg::word_t exp_result, input logic exp_fault);
        ops[n_rows] = '{addr, wdata, funct3, store, src, exp_result, exp_fault};
        n_rows++;
    endtask

    task automatic fill_table();
        // word store, then loads of each size and offset.
        add_row(32'h40, 32'h8899aabb, mem_stage_pkg::F3_W, 1'b1, mem_stage_pkg::RES_ADDR,
                32'h40, 1'b0);
        add_row(32'h40, 32'h0, mem_stage_pkg::F3_W, 1'b0, mem_stage_pkg::RES_MEM,
                32'h8899aabb, 1'b0);
        add_row(32'h40, 32'h0, mem_stage_pkg::F3_B, 1'b0, mem_stage_pkg::RES_MEM,
                32'hffffffbb, 1'b0);
        add_row(32'h41, 32'h0, mem_stage_pkg::F3_BU, 1'b0, mem_stage_pkg::RES_MEM,
                32'h000000aa, 1'b0);
        add_row(32'h42, 32'h0, mem_stage_pkg::F3_B, 1'b0, mem_stage_pkg::RES_MEM,
                32'hffffff99, 1'b0);
        add_row(32'h43, 32'h0, mem_stage_pkg::F3_BU, 1'b0, mem_stage_pkg::RES_MEM,
                32'h00000088, 1'b0);
        add_row(32'h40, 32'h0, mem_stage_pkg::F3_H, 1'b0, mem_stage_pkg::RES_MEM,
                32'hffffaabb, 1'b0);
        add_row(32'h42, 32'h0, mem_stage_pkg::F3_HU, 1'b0, mem_stage_pkg::RES_MEM,
                32'h00008899, 1'b0);
        // partial stores return the old lanes and merge into the word.
        add_row(32'h41, 32'h00000055, mem_stage_pkg::F3_B, 1'b1, mem_stage_pkg::RES_MEM,
                32'hffffffaa, 1'b0);
        add_row(32'h42, 32'h00001234, mem_stage_pkg::F3_H, 1'b1, mem_stage_pkg::RES_MEM,
                32'hffff8899, 1'b0);
        add_row(32'h40, 32'h000000c3, mem_stage_pkg::F3_B, 1'b1, mem_stage_pkg::RES_ADDR,
                32'h40, 1'b0);
        add_row(32'h43, 32'h0000007f, mem_stage_pkg::F3_B, 1'b1, mem_stage_pkg::RES_ADDR,
                32'h43, 1'b0);
        add_row(32'h40, 32'h0, mem_stage_pkg::F3_W, 1'b0, mem_stage_pkg::RES_MEM,
                32'h7f3455c3, 1'b0);
        add_row(32'h42, 32'h0, mem_stage_pkg::F3_H, 1'b0, mem_stage_pkg::RES_MEM,
                32'h00007f34, 1'b0);
        // misaligned accesses fault and keep RESULT.
        add_row(32'h42, 32'hffffffff, mem_stage_pkg::F3_W, 1'b1, mem_stage_pkg::RES_ADDR,
                32'h00007f34, 1'b1);
        add_row(32'h41, 32'h0, mem_stage_pkg::F3_H, 1'b0, mem_stage_pkg::RES_MEM,
                32'h00007f34, 1'b1);
        add_row(32'h43, 32'h0000ffff, mem_stage_pkg::F3_H, 1'b1, mem_stage_pkg::RES_MEM,
                32'h00007f34, 1'b1);
        add_row(32'h40, 32'h0, mem_stage_pkg::F3_W, 1'b0, mem_stage_pkg::RES_MEM,
                32'h7f3455c3, 1'b0);
        add_row(32'h40, 32'h0, mem_stage_pkg::F3_W, 1'b0, mem_stage_pkg::RES_LINK,
                32'h44, 1'b0);
        add_row(32'h42, 32'h0, mem_stage_pkg::F3_B, 1'b0, 2'd3,
                32'h0, 1'b0);
        // upper address bits wrap.
        add_row(32'h12340440, 32'h0, mem_stage_pkg::F3_W, 1'b0, mem_stage_pkg::RES_MEM,
                32'h7f3455c3, 1'b0);
        add_row(32'hfffffc42, 32'h0, mem_stage_pkg::F3_HU, 1'b0, mem_stage_pkg::RES_ADDR,
                32'h42, 1'b0);
        add_row(32'h40, 32'h0000beef, mem_stage_pkg::F3_H, 1'b1, mem_stage_pkg::RES_MEM,
                32'h000055c3, 1'b0);
        add_row(32'h42, 32'h000000a5, mem_stage_pkg::F3_B, 1'b1, mem_stage_pkg::RES_MEM,
                32'h00000034, 1'b0);
        add_row(32'h40, 32'h0, mem_stage_pkg::F3_W, 1'b0, mem_stage_pkg::RES_MEM,
                32'h7fa5beef, 1'b0);
        add_row(32'h804, 32'h01020304, mem_stage_pkg::F3_W, 1'b1, mem_stage_pkg::RES_LINK,
                32'h8, 1'b0);
        add_row(32'h6, 32'h0, mem_stage_pkg::F3_B, 1'b0, mem_stage_pkg::RES_MEM,
                32'h2, 1'b0);
    endtask

    initial
    begin
        mem_stage_pkg::word_t data;
        clk         = 1'b0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        seed        = 96974;
        n_rows      = 0;
        fill_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        apb_read(mem_stage_pkg::REG_STATUS, data, 1'b0);
        check_status(data, 32'h0);
        apb_read(mem_stage_pkg::REG_RESULT, data, 1'b0);
        check_word("RESULT", data, 32'h0);

        for (int i = 0; i < n_rows; i++)
            run_op(ops[i]);

        // rejected accesses launch nothing.
        apb_write(8'h14, 32'h1, 1'b1);
        apb_read(8'h40, data, 1'b1);
        apb_write(mem_stage_pkg::REG_RESULT, 32'hffffffff, 1'b1);
        apb_write(mem_stage_pkg::REG_CMD, 32'h00000013, 1'b1);
        apb_write(mem_stage_pkg::REG_CMD, 32'h0000001c, 1'b1);
        apb_write(mem_stage_pkg::REG_CMD, 32'h00000017, 1'b1);
        apb_read(mem_stage_pkg::REG_STATUS, data, 1'b0);
        check_status(data, 32'h0);
        apb_read(mem_stage_pkg::REG_RESULT, data, 1'b0);
        check_word("RESULT", data, ops[n_rows - 1].exp_result);

        run_random(INIT_WORDS, 1'b1);
        run_random(NUM_RANDOM, 1'b0);

        if (i_mem_stage_top.i_mem_stage_props.fail_count == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("a bound assertion failed during the run");
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // about 40 cycles per operation.
    initial
    begin
        #1;
        repeat ((n_rows + INIT_WORDS + NUM_RANDOM + 10) * 40 + 200) @(posedge clk);
        $display("timeout: the test sequence did not finish in time");
        $display("TESTBENCH FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

/* verilog/access_decode.sv */
`timescale 1ns/1ns

module access_decode (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          launch,
    input  mem_stage_pkg::word_t          cmd_addr,
    input  mem_stage_pkg::word_t          cmd_wdata,
    input  mem_stage_pkg::funct3_t        cmd_funct3,
    input  logic                          cmd_store,
    input  mem_stage_pkg::result_src_t    cmd_result_src,
    mem_req_if.src                        req,
    output logic                          fault
);

    logic [1:0]               offset;
    logic                     misaligned;
    mem_stage_pkg::byte_en_t  lane_mask;

    assign offset = cmd_addr[1:0];

    // size is in the low two bits for signed and unsigned codes alike.
    always_comb
    begin
        misaligned = 1'b0;
        case (cmd_funct3[1:0])
            2'b00:
            begin
                lane_mask = mem_stage_pkg::byte_en_t'(4'b0001 << offset);
            end
            2'b01:
            begin
                lane_mask  = mem_stage_pkg::byte_en_t'(4'b0011 << offset);
                misaligned = offset[0];
            end
            default:
            begin
                lane_mask  = 4'b1111;
                misaligned = (offset != 2'b00);
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            req.valid <= 1'b0;
            fault     <= 1'b0;
        end
        else
        begin
            req.valid <= launch && !misaligned;
            fault     <= launch && misaligned;
        end
    end

    // payload, qualified by valid.
    always_ff @(posedge clk)
    begin
        if (launch)
        begin
            req.word_index  <= cmd_addr[mem_stage_pkg::MEM_AW+1:2];
            req.byte_offset <= offset;
            req.wdata       <= cmd_wdata << {offset, 3'b000};
            req.byte_en     <= cmd_store ? lane_mask : 4'b0000;
            req.store       <= cmd_store;
            req.funct3      <= cmd_funct3;
            req.result_src  <= cmd_result_src;
        end
    end

endmodule

/* verilog/apb_cmd_port.sv */
`timescale 1ns/1ns

module apb_cmd_port (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  mem_stage_pkg::paddr_t         paddr,
    input  mem_stage_pkg::word_t          pwdata,
    input  logic                          fault,
    input  logic                          result_valid,
    input  mem_stage_pkg::word_t          result,
    output mem_stage_pkg::word_t          prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          launch,
    output mem_stage_pkg::word_t          cmd_addr,
    output mem_stage_pkg::word_t          cmd_wdata,
    output mem_stage_pkg::funct3_t        cmd_funct3,
    output logic                          cmd_store,
    output mem_stage_pkg::result_src_t    cmd_result_src
);

    logic                    access;
    logic                    wr;
    logic                    mapped;
    logic                    cmd_legal;
    logic                    cmd_ok;
    logic [1:0]              in_flight;
    logic                    fault_q;
    mem_stage_pkg::word_t    result_q;
    mem_stage_pkg::funct3_t  wr_funct3;

    assign pready = 1'b1;
    assign access = psel && penable;
    assign wr     = access && pwrite;

    // cmd layout: [2:0] funct3, [3] store, [5:4] result select.
    assign wr_funct3 = pwdata[2:0];
    always_comb
    begin
        cmd_legal = (wr_funct3 == mem_stage_pkg::F3_B) ||
                    (wr_funct3 == mem_stage_pkg::F3_H) ||
                    (wr_funct3 == mem_stage_pkg::F3_W);
        // unsigned codes are loads only.
        if (!pwdata[3])
        begin
            cmd_legal = cmd_legal || (wr_funct3 == mem_stage_pkg::F3_BU) ||
                        (wr_funct3 == mem_stage_pkg::F3_HU);
        end
    end

    assign cmd_ok = wr && (paddr == mem_stage_pkg::REG_CMD) && cmd_legal;

    always_comb
    begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            mem_stage_pkg::REG_ADDR:   prdata = cmd_addr;
            mem_stage_pkg::REG_WDATA:  prdata = cmd_wdata;
            mem_stage_pkg::REG_CMD:    prdata = {26'b0, cmd_result_src, cmd_store, cmd_funct3};
            mem_stage_pkg::REG_RESULT: prdata = result_q;
            mem_stage_pkg::REG_STATUS: prdata = {30'b0, fault_q, in_flight != 2'd0};
            default:                   mapped = 1'b0;
        endcase
    end

    assign pslverr = access && (!mapped ||
                     (pwrite && paddr == mem_stage_pkg::REG_RESULT) ||
                     (pwrite && paddr == mem_stage_pkg::REG_CMD && !cmd_legal));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cmd_addr       <= '0;
            cmd_wdata      <= '0;
            cmd_funct3     <= '0;
            cmd_store      <= 1'b0;
            cmd_result_src <= '0;
            launch         <= 1'b0;
            in_flight      <= '0;
            fault_q        <= 1'b0;
            result_q       <= '0;
        end
        else
        begin
            launch <= cmd_ok;
            if (wr && paddr == mem_stage_pkg::REG_ADDR)
                cmd_addr <= pwdata;
            if (wr && paddr == mem_stage_pkg::REG_WDATA)
                cmd_wdata <= pwdata;
            if (cmd_ok)
            begin
                cmd_funct3     <= wr_funct3;
                cmd_store      <= pwdata[3];
                cmd_result_src <= pwdata[5:4];
            end
            // a fault and a completion can land in the same cycle.
            in_flight <= in_flight + {1'b0, cmd_ok} - {1'b0, fault} - {1'b0, result_valid};
            if (fault)
                fault_q <= 1'b1;
            else if (wr && paddr == mem_stage_pkg::REG_STATUS && pwdata[1])
                fault_q <= 1'b0;
            if (result_valid)
                result_q <= result;
        end
    end

endmodule

/* verilog/data_mem.sv */
`timescale 1ns/1ns

module data_mem (
    input  logic    clk,
    mem_req_if.dst  req,
    mem_rsp_if.src  rsp
);

    // lane i holds byte i of each word, little-endian.
    logic [7:0] mem [4][mem_stage_pkg::MEM_WORDS];

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (req.valid)
            begin
                rsp.rdata[8*i +: 8] <= mem[i][req.word_index];
                if (req.store && req.byte_en[i])
                    mem[i][req.word_index] <= req.wdata[8*i +: 8];
            end
        end
    end

    // follows req.valid, which is reset upstream.
    always_ff @(posedge clk)
    begin
        rsp.valid <= req.valid;
    end

    always_ff @(posedge clk)
    begin
        if (req.valid)
        begin
            // address as seen by the memory, wrapped to its size.
            rsp.addr       <= mem_stage_pkg::word_t'({req.word_index, req.byte_offset});
            rsp.funct3     <= req.funct3;
            rsp.result_src <= req.result_src;
        end
    end

endmodule

/* verilog/load_result.sv */
`timescale 1ns/1ns

module load_result (
    input  logic                    clk,
    input  logic                    rst_n,
    mem_rsp_if.dst                  rsp,
    output logic                    result_valid,
    output mem_stage_pkg::word_t    result
);

    mem_stage_pkg::word_t lane_data;
    mem_stage_pkg::word_t ext_data;
    mem_stage_pkg::word_t sel_data;

    // addressed byte or halfword moved down to bit 0.
    assign lane_data = rsp.rdata >> {rsp.addr[1:0], 3'b000};

    always_comb
    begin
        case (rsp.funct3)
            mem_stage_pkg::F3_B:  ext_data = {{24{lane_data[7]}}, lane_data[7:0]};
            mem_stage_pkg::F3_H:  ext_data = {{16{lane_data[15]}}, lane_data[15:0]};
            mem_stage_pkg::F3_W:  ext_data = rsp.rdata;
            mem_stage_pkg::F3_BU: ext_data = {24'b0, lane_data[7:0]};
            mem_stage_pkg::F3_HU: ext_data = {16'b0, lane_data[15:0]};
            default:              ext_data = '0;
        endcase
    end

    always_comb
    begin
        case (rsp.result_src)
            mem_stage_pkg::RES_MEM:  sel_data = ext_data;
            mem_stage_pkg::RES_ADDR: sel_data = rsp.addr;
            mem_stage_pkg::RES_LINK: sel_data = rsp.addr + 32'd4;
            default:                 sel_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            result_valid <= 1'b0;
        else
            result_valid <= rsp.valid;
    end

    always_ff @(posedge clk)
    begin
        if (rsp.valid)
            result <= sel_data;
    end

endmodule

/* verilog/mem_stage_ifs.sv */
`timescale 1ns/1ns

// decode to execute.
interface mem_req_if;
    logic                                valid;
    logic [mem_stage_pkg::MEM_AW-1:0]    word_index;
    mem_stage_pkg::word_t                wdata;
    mem_stage_pkg::byte_en_t             byte_en;
    logic                                store;
    logic [1:0]                          byte_offset;
    mem_stage_pkg::funct3_t              funct3;
    mem_stage_pkg::result_src_t          result_src;

    modport src (output valid, word_index, wdata, byte_en, store, byte_offset,
                 funct3, result_src);
    modport dst (input valid, word_index, wdata, byte_en, store, byte_offset,
                 funct3, result_src);
endinterface

// execute to result.
interface mem_rsp_if;
    logic                          valid;
    mem_stage_pkg::word_t          rdata;
    mem_stage_pkg::word_t          addr;
    mem_stage_pkg::funct3_t        funct3;
    mem_stage_pkg::result_src_t    result_src;

    modport src (output valid, rdata, addr, funct3, result_src);
    modport dst (input valid, rdata, addr, funct3, result_src);
endinterface

/* verilog/mem_stage_pkg.sv */
package mem_stage_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [1:0]  result_src_t;
    typedef logic [7:0]  paddr_t;

    // rv32 load and store function codes.
    localparam funct3_t F3_B  = 3'd0;
    localparam funct3_t F3_H  = 3'd1;
    localparam funct3_t F3_W  = 3'd2;
    localparam funct3_t F3_BU = 3'd4;
    localparam funct3_t F3_HU = 3'd5;

    // result select, 3 gives zero.
    localparam result_src_t RES_ADDR = 2'd0;
    localparam result_src_t RES_MEM  = 2'd1;
    localparam result_src_t RES_LINK = 2'd2;

    // apb register map.
    localparam paddr_t REG_ADDR   = 8'h00;
    localparam paddr_t REG_WDATA  = 8'h04;
    localparam paddr_t REG_CMD    = 8'h08;
    localparam paddr_t REG_RESULT = 8'h0C;
    localparam paddr_t REG_STATUS = 8'h10;

    // data memory depth in words.
    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = 8;

endpackage

/* verilog/mem_stage_top.sv */
`timescale 1ns/1ns

module mem_stage_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  mem_stage_pkg::paddr_t    paddr,
    input  mem_stage_pkg::word_t     pwdata,
    output mem_stage_pkg::word_t     prdata,
    output logic                     pready,
    output logic                     pslverr
);

    logic                          launch;
    mem_stage_pkg::word_t          cmd_addr;
    mem_stage_pkg::word_t          cmd_wdata;
    mem_stage_pkg::funct3_t        cmd_funct3;
    logic                          cmd_store;
    mem_stage_pkg::result_src_t    cmd_result_src;
    logic                          fault;
    logic                          result_valid;
    mem_stage_pkg::word_t          result;

    mem_req_if req ();
    mem_rsp_if rsp ();

    apb_cmd_port i_apb_cmd_port (
        .clk            (clk),
        .rst_n          (rst_n),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .fault          (fault),
        .result_valid   (result_valid),
        .result         (result),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .launch         (launch),
        .cmd_addr       (cmd_addr),
        .cmd_wdata      (cmd_wdata),
        .cmd_funct3     (cmd_funct3),
        .cmd_store      (cmd_store),
        .cmd_result_src (cmd_result_src)
    );

    access_decode i_access_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .launch         (launch),
        .cmd_addr       (cmd_addr),
        .cmd_wdata      (cmd_wdata),
        .cmd_funct3     (cmd_funct3),
        .cmd_store      (cmd_store),
        .cmd_result_src (cmd_result_src),
        .req            (req),
        .fault          (fault)
    );

    data_mem i_data_mem (
        .clk (clk),
        .req (req),
        .rsp (rsp)
    );

    load_result i_load_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .rsp          (rsp),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule
